// ==== rtl/pu_spi_cfg.svh ====
`ifndef PU_SPI_CFG_SVH
`define PU_SPI_CFG_SVH

////////////////////////////////////////////////////////////
// Processor side sizes
////////////////////////////////////////////////////////////

// Word written by the processor
`define PU_DATA_WIDTH 32

// Words held per bank
`define PU_BUF_SIZE 6

////////////////////////////////////////////////////////////
// SPI side sizes
////////////////////////////////////////////////////////////

`define PU_SPI_WIDTH 8
`define PU_BYTES_PER_WORD (`PU_DATA_WIDTH / `PU_SPI_WIDTH)

`endif

// ==== rtl/spi_link_pkg.sv ====
`include "pu_spi_cfg.svh"

package spi_link_pkg;

    // One byte on the SPI wire
    typedef logic [`PU_SPI_WIDTH-1:0] spi_byte_t;

    // Bit position within the byte being shifted
    typedef logic [$clog2(`PU_SPI_WIDTH)-1:0] bit_cnt_t;

    // Two flop synchronizer stages for one input line
    // Bit 1 is the stage safe to use in clk domain
    typedef logic [1:0] line_sync_t;

endpackage

// ==== rtl/pu_word_pkg.sv ====
`include "pu_spi_cfg.svh"

package pu_word_pkg;
    import spi_link_pkg::*;

    // One processor data word
    typedef logic [`PU_DATA_WIDTH-1:0] pu_word_t;

    // Same bits seen as a word or as bytes
    // Byte 0 is the most significant one, sent first on miso
    typedef union packed {
        pu_word_t word;
        spi_byte_t [0:`PU_BYTES_PER_WORD-1] bytes;
    } pu_word_u;

    // Bank index or word count, covers 0 up to a full bank
    typedef logic [$clog2(`PU_BUF_SIZE + 1)-1:0] buf_idx_t;

    // Byte position inside a word
    typedef logic [$clog2(`PU_BYTES_PER_WORD)-1:0] byte_idx_t;

endpackage

// ==== rtl/pingpong_word_buffer.sv ====
`include "pu_spi_cfg.svh"

module pingpong_word_buffer import pu_word_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     signal_cycle,
    input  logic     idle,
    input  logic     signal_wr,
    input  pu_word_t data_in,
    input  logic     flag_stop,
    output logic     word_valid,
    input  logic     word_ready,
    output pu_word_t word
);

    // Two banks, bank_sel points at the one the processor fills
    pu_word_t mem [2][`PU_BUF_SIZE];
    buf_idx_t wr_cnt [2];
    buf_idx_t rd_ptr;
    logic     bank_sel;
    logic     rd_sel;

    logic     swap;
    logic     wr_ok;
    logic     rd_fire;

    assign rd_sel = ~bank_sel;

    // Swap only with cs high so SPI never sees a half written bank
    assign swap = signal_cycle && idle;

    // Drop writes once the bank is full
    assign wr_ok = signal_wr && (wr_cnt[bank_sel] < buf_idx_t'(`PU_BUF_SIZE));

    assign word_valid = rd_ptr < wr_cnt[rd_sel];
    assign word       = mem[rd_sel][rd_ptr];
    assign rd_fire    = word_valid && word_ready;

    ////////////////////////////////////////////////////////////
    // Bank storage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[bank_sel][wr_cnt[bank_sel]] <= data_in;
        end
    end

    ////////////////////////////////////////////////////////////
    // Counts, bank select and read pointer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            bank_sel  <= 1'b0;
            wr_cnt[0] <= '0;
            wr_cnt[1] <= '0;
            rd_ptr    <= '0;
        end else begin
            if (wr_ok) begin
                wr_cnt[bank_sel] <= wr_cnt[bank_sel] + 1'b1;
            end

            if (swap) begin
                // Old read bank turns into the new, empty write bank
                bank_sel       <= ~bank_sel;
                wr_cnt[rd_sel] <= '0;
                rd_ptr         <= '0;
            end else if (flag_stop) begin
                // Leftover words of an aborted transaction are discarded
                wr_cnt[rd_sel] <= '0;
                rd_ptr         <= '0;
            end else if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // Reader stays inside the words actually written
    a_rd_ptr_in_range: assert property (
        @(posedge clk) disable iff (rst)
        rd_ptr <= wr_cnt[rd_sel]
    ) else $error("read pointer beyond read bank count");

endmodule

// ==== rtl/word_to_byte_splitter.sv ====
`include "pu_spi_cfg.svh"

module word_to_byte_splitter
    import spi_link_pkg::*;
    import pu_word_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      flag_stop,
    input  logic      word_valid,
    output logic      word_ready,
    input  pu_word_t  word,
    output logic      byte_valid,
    input  logic      byte_ready,
    output spi_byte_t tx_byte
);

    pu_word_u  held;
    byte_idx_t idx;
    logic      full;
    logic      last;
    logic      byte_fire;
    logic      word_fire;

    assign last      = idx == byte_idx_t'(`PU_BYTES_PER_WORD - 1);
    assign byte_fire = byte_valid && byte_ready;

    // Take the next word while the last byte leaves, no bubble
    assign word_ready = (!full || (byte_ready && last)) && !flag_stop;
    assign word_fire  = word_valid && word_ready;

    assign byte_valid = full;
    assign tx_byte    = held.bytes[idx];

    // Word payload
    always_ff @(posedge clk) begin
        if (word_fire) begin
            held.word <= word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
            idx  <= '0;
        end else if (flag_stop) begin
            full <= 1'b0;
            idx  <= '0;
        end else if (word_fire) begin
            full <= 1'b1;
            idx  <= '0;
        end else if (byte_fire) begin
            if (last) begin
                full <= 1'b0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    // Offered byte stays until taken or the transaction ends
    a_byte_held: assert property (
        @(posedge clk) disable iff (rst)
        byte_valid && !byte_ready && !flag_stop |=> byte_valid
    ) else $error("byte_valid dropped without transfer");

endmodule

// ==== rtl/spi_slave_shifter.sv ====
`include "pu_spi_cfg.svh"

module spi_slave_shifter import spi_link_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      sclk,
    input  logic      cs,
    output logic      miso,
    output logic      idle,
    input  logic      byte_valid,
    output logic      byte_ready,
    input  spi_byte_t tx_byte,
    output logic      flag_start,
    output logic      flag_stop
);

    line_sync_t cs_pipe;
    line_sync_t sclk_pipe;
    logic       cs_s;
    logic       cs_q;
    logic       sclk_s;
    logic       sclk_q;

    logic       cs_fall;
    logic       cs_rise;
    logic       sclk_rise;
    logic       sclk_fall;

    logic       active;
    logic       last_bit;
    logic       load;
    bit_cnt_t   bit_cnt;
    spi_byte_t  shift_reg;

    ////////////////////////////////////////////////////////////
    // Line synchronizers and edge detect
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            cs_pipe   <= '1;
            sclk_pipe <= '0;
            cs_q      <= 1'b1;
            sclk_q    <= 1'b0;
        end else begin
            cs_pipe   <= {cs_pipe[0], cs};
            sclk_pipe <= {sclk_pipe[0], sclk};
            cs_q      <= cs_s;
            sclk_q    <= sclk_s;
        end
    end

    assign cs_s   = cs_pipe[1];
    assign sclk_s = sclk_pipe[1];
    assign idle   = cs_s;

    assign cs_fall = cs_q && !cs_s;
    assign cs_rise = !cs_q && cs_s;

    // Clock edges only count inside a started transaction
    assign sclk_rise = active && !cs_s && sclk_s && !sclk_q;
    assign sclk_fall = active && !cs_s && !sclk_s && sclk_q;

    ////////////////////////////////////////////////////////////
    // Transaction flags
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            active     <= 1'b0;
            flag_start <= 1'b0;
            flag_stop  <= 1'b0;
        end else begin
            flag_start <= cs_fall && !active;
            flag_stop  <= cs_rise && active;
            if (cs_fall) begin
                active <= 1'b1;
            end else if (cs_rise) begin
                active <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Byte shifter, mode 0
    ////////////////////////////////////////////////////////////

    assign last_bit   = bit_cnt == bit_cnt_t'(`PU_SPI_WIDTH - 1);
    assign load       = flag_start || (sclk_rise && last_bit);
    assign byte_ready = load;
    assign miso       = shift_reg[`PU_SPI_WIDTH-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt   <= '0;
            shift_reg <= '0;
        end else if (cs_s) begin
            bit_cnt   <= '0;
            shift_reg <= '0;
        end else if (load) begin
            // Underrun sends 0x00
            shift_reg <= byte_valid ? tx_byte : '0;
            bit_cnt   <= '0;
        end else begin
            if (sclk_rise) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            // Falling edge right after a load keeps the fresh MSB on miso
            if (sclk_fall && bit_cnt != '0) begin
                shift_reg <= {shift_reg[`PU_SPI_WIDTH-2:0], 1'b0};
            end
        end
    end

    a_flags_exclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(flag_start && flag_stop)
    ) else $error("flag_start and flag_stop together");

endmodule

// ==== rtl/pu_slave_spi.sv ====
module pu_slave_spi
    import spi_link_pkg::*;
    import pu_word_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     signal_cycle,
    input  logic     signal_wr,
    input  pu_word_t data_in,
    output logic     flag_start,
    output logic     flag_stop,
    output logic     miso,
    input  logic     sclk,
    input  logic     cs
);

    // Buffer to splitter
    logic      word_valid;
    logic      word_ready;
    pu_word_t  word;

    // Splitter to shifter
    logic      byte_valid;
    logic      byte_ready;
    spi_byte_t tx_byte;

    // Synchronized cs from the shifter
    logic      idle;

    pingpong_word_buffer buffer_inst (
        .clk          (clk),
        .rst          (rst),
        .signal_cycle (signal_cycle),
        .idle         (idle),
        .signal_wr    (signal_wr),
        .data_in      (data_in),
        .flag_stop    (flag_stop),
        .word_valid   (word_valid),
        .word_ready   (word_ready),
        .word         (word)
    );

    word_to_byte_splitter splitter_inst (
        .clk        (clk),
        .rst        (rst),
        .flag_stop  (flag_stop),
        .word_valid (word_valid),
        .word_ready (word_ready),
        .word       (word),
        .byte_valid (byte_valid),
        .byte_ready (byte_ready),
        .tx_byte    (tx_byte)
    );

    spi_slave_shifter shifter_inst (
        .clk        (clk),
        .rst        (rst),
        .sclk       (sclk),
        .cs         (cs),
        .miso       (miso),
        .idle       (idle),
        .byte_valid (byte_valid),
        .byte_ready (byte_ready),
        .tx_byte    (tx_byte),
        .flag_start (flag_start),
        .flag_stop  (flag_stop)
    );

endmodule

// ==== bench/pu_slave_spi_tb.sv ====
`include "pu_spi_cfg.svh"

module pu_slave_spi_tb
    import spi_link_pkg::*;
    import pu_word_pkg::*;
();

    localparam int    MAX_CASES = 32;
    localparam int    MAX_WORDS = 8;
    localparam string CASE_FILE = "bench/spi_cases.txt";

    logic     clk;
    logic     rst;
    logic     signal_cycle;
    logic     signal_wr;
    pu_word_t data_in;
    logic     flag_start;
    logic     flag_stop;
    logic     miso;
    logic     sclk;
    logic     cs;

    pu_word_t case_words [MAX_CASES][MAX_WORDS];
    int       case_nwords [MAX_CASES];
    int       case_nbytes [MAX_CASES];
    int       num_cases;
    bit       cases_loaded;

    // Running totals of flag pulses
    int       start_cnt;
    int       stop_cnt;

    pu_slave_spi pu_slave_spi_inst (
        .clk          (clk),
        .rst          (rst),
        .signal_cycle (signal_cycle),
        .signal_wr    (signal_wr),
        .data_in      (data_in),
        .flag_start   (flag_start),
        .flag_stop    (flag_stop),
        .miso         (miso),
        .sclk         (sclk),
        .cs           (cs)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Case file and expected bytes
    ////////////////////////////////////////////////////////////

    task automatic load_cases();
        int       fd;
        int       n;
        int       nb;
        int       i;
        string    line;
        pu_word_t w [MAX_WORDS];
        num_cases = 0;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the case file %s", CASE_FILE);
            $display("TEST FAIL");
            $fatal(1, "case file missing");
        end else begin
            while ($fgets(line, fd) != 0) begin
                // Lines starting with # only describe the columns
                if (line.len() > 0 && line.getc(0) != "#" && num_cases < MAX_CASES) begin
                    if ($sscanf(line, "%d %h %h %h %h %h %h %h %h %d", n,
                            w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7], nb) == 10) begin
                        for (i = 0; i < MAX_WORDS; i++) begin
                            case_words[num_cases][i] = w[i];
                        end
                        case_nwords[num_cases] = n;
                        case_nbytes[num_cases] = nb;
                        num_cases++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Bank keeps at most PU_BUF_SIZE words, sent MSB first, then 0x00
    function automatic spi_byte_t expected_byte(input int case_no, input int k);
        int       kept;
        int       w;
        int       pos;
        pu_word_t value;
        kept = case_nwords[case_no];
        if (kept > `PU_BUF_SIZE) begin
            kept = `PU_BUF_SIZE;
        end
        w   = k / `PU_BYTES_PER_WORD;
        pos = k % `PU_BYTES_PER_WORD;
        if (w >= kept) begin
            return '0;
        end
        value = case_words[case_no][w];
        return spi_byte_t'(value >> (`PU_SPI_WIDTH * (`PU_BYTES_PER_WORD - 1 - pos)));
    endfunction

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    task automatic check_byte(input spi_byte_t got, input spi_byte_t exp,
                              input int case_no, input int idx);
        if (got !== exp) begin
            $display("Error: time %0t: case %0d byte %0d on miso is %02h, expected %02h",
                     $time, case_no, idx, got, exp);
            $display("TEST FAIL");
            $fatal(1, "miso byte mismatch");
        end
    endtask

    task automatic check_flags(input int starts, input int stops, input int case_no);
        if (starts != 1 || stops != 1) begin
            $display("Error: time %0t: case %0d saw %0d start and %0d stop pulses, expected 1 and 1",
                     $time, case_no, starts, stops);
            $display("TEST FAIL");
            $fatal(1, "flag count mismatch");
        end
    endtask

    // Sampled on the falling edge, away from flag updates
    always @(negedge clk) begin
        if (!rst && flag_stop && stop_cnt >= start_cnt) begin
            $display("Error: time %0t: flag_stop pulse without an open flag_start", $time);
            $display("TEST FAIL");
            $fatal(1, "flag order");
        end
        if (!rst && flag_start) begin
            start_cnt = start_cnt + 1;
        end
        if (!rst && flag_stop) begin
            stop_cnt = stop_cnt + 1;
        end
    end

    // Watchdog sized from the case lengths
    initial begin
        int limit_cycles;
        int c;
        wait (cases_loaded);
        limit_cycles = 16;
        for (c = 0; c < num_cases; c++) begin
            limit_cycles += case_nwords[c] * 2 + case_nbytes[c] * 64 + 200;
        end
        repeat (limit_cycles) @(posedge clk);
        $display("The run timed out after %0d clock cycles", limit_cycles);
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

    ////////////////////////////////////////////////////////////
    // Processor and SPI master
    ////////////////////////////////////////////////////////////

    // Drive point is 10 units after the rising edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #10;
    endtask

    task automatic write_words(input int case_no);
        int i;
        for (i = 0; i < case_nwords[case_no]; i++) begin
            signal_wr = 1'b1;
            data_in   = case_words[case_no][i];
            wait_cycles(1);
        end
        signal_wr = 1'b0;
    endtask

    task automatic pulse_cycle();
        signal_cycle = 1'b1;
        wait_cycles(1);
        signal_cycle = 1'b0;
    endtask

    // Mode 0 master, half period of 4 clk cycles
    task automatic run_transaction(input int case_no);
        int        k;
        int        b;
        spi_byte_t got;
        cs = 1'b0;
        wait_cycles(8);
        for (k = 0; k < case_nbytes[case_no]; k++) begin
            got = '0;
            for (b = 0; b < `PU_SPI_WIDTH; b++) begin
                sclk = 1'b1;
                got  = {got[`PU_SPI_WIDTH-2:0], miso};
                wait_cycles(4);
                sclk = 1'b0;
                wait_cycles(4);
            end
            check_byte(got, expected_byte(case_no, k), case_no, k);
        end
        cs = 1'b1;
        wait_cycles(8);
    endtask

    initial begin
        int c;
        int start_base;
        int stop_base;
        rst          = 1'b1;
        signal_cycle = 1'b0;
        signal_wr    = 1'b0;
        data_in      = '0;
        sclk         = 1'b0;
        cs           = 1'b1;
        load_cases();
        cases_loaded = 1'b1;
        if (num_cases == 0) begin
            $display("The case file holds no usable case");
            $display("TEST FAIL");
            $fatal(1, "no cases");
        end else begin
            repeat (16) @(posedge clk);
            #10;
            rst = 1'b0;
            wait_cycles(4);
            write_words(0);
            for (c = 0; c < num_cases; c++) begin
                start_base = start_cnt;
                stop_base  = stop_cnt;
                wait_cycles(4);
                pulse_cycle();
                wait_cycles(4);
                // Next case's words go into the write bank during this transaction
                fork
                    run_transaction(c);
                    if (c + 1 < num_cases) begin
                        write_words(c + 1);
                    end
                join
                check_flags(start_cnt - start_base, stop_cnt - stop_base, c);
            end
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// ==== bench/spi_cases.txt ====
# nwords w0 w1 w2 w3 w4 w5 w6 w7 nbytes
# nwords and nbytes in decimal, words in hex, unused word columns hold 00000000
4 11223344 55667788 99aabbcc ddeeff00 00000000 00000000 00000000 00000000 16
# seven words written, the seventh is dropped and its bytes read as zero
7 a0a1a2a3 b0b1b2b3 c0c1c2c3 d0d1d2d3 e0e1e2e3 f0f1f2f3 0badf00d 00000000 28
2 12345678 9abcdef0 00000000 00000000 00000000 00000000 00000000 00000000 12
# truncated read, the rest of the bank is discarded
5 01020304 05060708 090a0b0c 0d0e0f10 11121314 00000000 00000000 00000000 6
3 cafe0001 cafe0002 cafe0003 00000000 00000000 00000000 00000000 00000000 12
0 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 4
6 80000001 40000002 20000004 10000008 08000010 04000020 00000000 00000000 24
1 deadbeef 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0
6 0f1e2d3c 4b5a6978 8796a5b4 c3d2e1f0 ffffffff 00ff00ff 00000000 00000000 3
4 13579bdf 2468ace0 fedcba98 76543210 00000000 00000000 00000000 00000000 16
8 a5a5a5a5 5a5a5a5a 3c3c3c3c c3c3c3c3 96969696 69696969 77777777 88888888 26
1 00000001 00000000 00000000 00000000 00000000 00000000 00000000 00000000 8
3 aabbccdd 00000000 ffffffff 00000000 00000000 00000000 00000000 00000000 11

// ==== sources.f ====
+incdir+rtl
rtl/spi_link_pkg.sv
rtl/pu_word_pkg.sv
rtl/pingpong_word_buffer.sv
rtl/word_to_byte_splitter.sv
rtl/spi_slave_shifter.sv
rtl/pu_slave_spi.sv
bench/pu_slave_spi_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module pu_slave_spi_tb \
    --Mdir obj_dir \
    -f sources.f

./obj_dir/Vpu_slave_spi_tb
